//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = z8LiteTb
FILELIST = z8Lite.f

BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/z8Alu.sv
`timescale 1ns/1ps

module z8Alu (
    input  z8LitePkg::aluOpE aluOp,
    input  logic [7:0]       aluA,
    input  logic [7:0]       aluB,
    input  logic [7:0]       flagsIn,
    output logic [7:0]       aluOut,
    output logic [7:0]       flagsOut
);

    import z8LitePkg::*;

    logic [8:0] wide;
    logic       carryIn;
    logic       isArith;
    logic       isSub;
    logic       isLogic;

    assign carryIn = flagsIn[FLAG_C];
    assign isSub   = (aluOp == ALU_SUB) || (aluOp == ALU_SBC) || (aluOp == ALU_CP);
    assign isArith = isSub || (aluOp == ALU_ADD) || (aluOp == ALU_ADC);
    assign isLogic = (aluOp == ALU_OR) || (aluOp == ALU_AND) || (aluOp == ALU_XOR);

    always_comb begin
        case (aluOp)
            ALU_LD:  wide = {1'b0, aluB};
            ALU_ADD: wide = {1'b0, aluA} + {1'b0, aluB};
            ALU_ADC: wide = {1'b0, aluA} + {1'b0, aluB} + {8'h00, carryIn};
            ALU_SUB: wide = {1'b0, aluA} - {1'b0, aluB};
            ALU_CP:  wide = {1'b0, aluA} - {1'b0, aluB};
            ALU_SBC: wide = {1'b0, aluA} - {1'b0, aluB} - {8'h00, carryIn};
            ALU_OR:  wide = {1'b0, aluA | aluB};
            ALU_AND: wide = {1'b0, aluA & aluB};
            ALU_XOR: wide = {1'b0, aluA ^ aluB};
            ALU_DEC: wide = {1'b0, aluA} - 9'd1;
            default: wide = {1'b0, aluA};
        endcase
        aluOut = wide[7:0];
    end

    // Only arithmetic and logic ops touch the flags, low nibble always kept
    always_comb begin
        flagsOut = flagsIn;
        if (isArith || isLogic) begin
            flagsOut[FLAG_Z] = (aluOut == 8'h00);
            flagsOut[FLAG_S] = aluOut[7];
        end
        if (isArith) begin
            // Bit 8 is carry for add and borrow for subtract
            flagsOut[FLAG_C] = wide[8];
            if (isSub) begin
                flagsOut[FLAG_V] = (aluA[7] != aluB[7]) && (aluOut[7] != aluA[7]);
            end else begin
                flagsOut[FLAG_V] = (aluA[7] == aluB[7]) && (aluOut[7] != aluA[7]);
            end
        end
        if (isLogic) begin
            flagsOut[FLAG_V] = 1'b0;
        end
    end

endmodule

//--- hw/z8Lite.sv
`timescale 1ns/1ps
`include "z8Lite_defines.svh"

module z8Lite (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   loadEn,
    input  logic [`MEM_ADDR_W-1:0] loadAddr,
    input  logic [7:0]             loadData,
    output z8LitePkg::wbT          wb,
    output logic [7:0]             flags
);

    import z8LitePkg::*;

    logic                   memStrobe;
    logic [`MEM_ADDR_W-1:0] memAddr;
    logic [7:0]             memData;
    logic [7:0]             rdAddrA;
    logic [7:0]             rdAddrB;
    logic [7:0]             rdDataA;
    logic [7:0]             rdDataB;
    aluOpE                  aluOp;
    logic [7:0]             aluA;
    logic [7:0]             aluB;
    logic [7:0]             aluOut;
    logic [7:0]             flagsOut;
    logic                   flagsWe;
    logic [1:0]             carrySet;

    z8ProgMem progMem (
        .clk       (clk),
        .rstN      (rstN),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .memStrobe (memStrobe),
        .memAddr   (memAddr),
        .memData   (memData)
    );

    z8Sequencer sequencer (
        .clk       (clk),
        .rstN      (rstN),
        .memStrobe (memStrobe),
        .memAddr   (memAddr),
        .memData   (memData),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .aluOp     (aluOp),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluOut    (aluOut),
        .flags     (flags),
        .wb        (wb),
        .flagsWe   (flagsWe),
        .carrySet  (carrySet)
    );

    z8RegFile regFile (
        .clk      (clk),
        .rstN     (rstN),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .wb       (wb),
        .flagsWe  (flagsWe),
        .flagsIn  (flagsOut),
        .carrySet (carrySet),
        .flags    (flags)
    );

    z8Alu alu (
        .aluOp    (aluOp),
        .aluA     (aluA),
        .aluB     (aluB),
        .flagsIn  (flags),
        .aluOut   (aluOut),
        .flagsOut (flagsOut)
    );

endmodule

//--- hw/z8LitePkg.sv
package z8LitePkg;

    // First instruction byte, seen either as ALU op or as register/cc number
    typedef union packed {
        struct packed {
            logic [3:0] op;
            logic [3:0] form;
        } aluForm;
        struct packed {
            logic [3:0] num;
            logic [3:0] form;
        } regForm;
    } opcodeU;

    // Second instruction byte
    typedef union packed {
        struct packed {
            logic [3:0] dst;
            logic [3:0] src;
        } regPair;
        logic signed [7:0] disp;
    } operandU;

    typedef enum logic [3:0] {
        ALU_LD,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_CP,
        ALU_DEC
    } aluOpE;

    localparam int FLAG_C = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_S = 5;
    localparam int FLAG_V = 4;

    // Carry commands from scf, rcf and ccf
    localparam logic [1:0] CARRY_KEEP = 2'd0;
    localparam logic [1:0] CARRY_SET  = 2'd1;
    localparam logic [1:0] CARRY_CLR  = 2'd2;
    localparam logic [1:0] CARRY_CPL  = 2'd3;

    // Control registers in the register space
    localparam logic [7:0] ADDR_FLAGS = 8'hFC;
    localparam logic [7:0] ADDR_RP    = 8'hFD;
    localparam logic [3:0] WORK_PREFIX = 4'hE;

    typedef struct packed {
        logic       valid;
        logic [7:0] addr;
        logic [7:0] data;
    } wbT;

    // Ex addresses a working register in the bank selected by rp
    function automatic logic [7:0] workAddr(input logic [7:0] a, input logic [3:0] ptr);
        if (a[7:4] == WORK_PREFIX) begin
            return {ptr, a[3:0]};
        end
        return a;
    endfunction

endpackage

//--- hw/z8Lite_defines.svh
`ifndef Z8LITE_DEFINES_SVH
`define Z8LITE_DEFINES_SVH

// Program memory geometry
`define MEM_DEPTH 4096
`define MEM_ADDR_W 12

// Program counter
`define PC_W 16
`define RESET_PC 16'h000C

// General purpose registers, 00 up to REG_COUNT-1
`define REG_COUNT 128

`endif

//--- hw/z8ProgMem.sv
`timescale 1ns/1ps
`include "z8Lite_defines.svh"

module z8ProgMem (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   loadEn,
    input  logic [`MEM_ADDR_W-1:0] loadAddr,
    input  logic [7:0]             loadData,
    input  logic                   memStrobe,
    input  logic [`MEM_ADDR_W-1:0] memAddr,
    output logic [7:0]             memData
);

    logic [7:0] mem [`MEM_DEPTH];

    // Loading is only accepted while the core is held in reset
    always_ff @(posedge clk) begin
        if (loadEn && !rstN) begin
            mem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (memStrobe) begin
            memData <= mem[memAddr];
        end
    end

endmodule

//--- hw/z8RegFile.sv
`timescale 1ns/1ps
`include "z8Lite_defines.svh"

module z8RegFile (
    input  logic          clk,
    input  logic          rstN,
    input  logic [7:0]    rdAddrA,
    input  logic [7:0]    rdAddrB,
    output logic [7:0]    rdDataA,
    output logic [7:0]    rdDataB,
    input  z8LitePkg::wbT wb,
    input  logic          flagsWe,
    input  logic [7:0]    flagsIn,
    input  logic [1:0]    carrySet,
    output logic [7:0]    flags
);

    import z8LitePkg::*;

    localparam int RegIdxW = $clog2(`REG_COUNT);

    logic [7:0] regs [`REG_COUNT];
    logic [3:0] rp;
    logic [7:0] mapA;
    logic [7:0] mapB;
    logic [7:0] wrAddr;

    assign mapA   = workAddr(rdAddrA, rp);
    assign mapB   = workAddr(rdAddrB, rp);
    assign wrAddr = workAddr(wb.addr, rp);

    always_comb begin
        rdDataA = 8'h00;
        if (mapA < `REG_COUNT) begin
            rdDataA = regs[mapA[RegIdxW-1:0]];
        end else if (mapA == ADDR_FLAGS) begin
            rdDataA = flags;
        end else if (mapA == ADDR_RP) begin
            rdDataA = {rp, 4'h0};
        end
    end

    always_comb begin
        rdDataB = 8'h00;
        if (mapB < `REG_COUNT) begin
            rdDataB = regs[mapB[RegIdxW-1:0]];
        end else if (mapB == ADDR_FLAGS) begin
            rdDataB = flags;
        end else if (mapB == ADDR_RP) begin
            rdDataB = {rp, 4'h0};
        end
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wrAddr < `REG_COUNT) begin
            regs[wrAddr[RegIdxW-1:0]] <= wb.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rp    <= 4'h0;
            flags <= 8'h00;
        end else begin
            if (wb.valid && wrAddr == ADDR_RP) begin
                rp <= wb.data[7:4];
            end
            if (flagsWe) begin
                flags <= flagsIn;
            end else begin
                case (carrySet)
                    CARRY_SET: flags[FLAG_C] <= 1'b1;
                    CARRY_CLR: flags[FLAG_C] <= 1'b0;
                    CARRY_CPL: flags[FLAG_C] <= ~flags[FLAG_C];
                    default: ;
                endcase
            end
            // A direct write to FC wins over the ALU flags
            if (wb.valid && wrAddr == ADDR_FLAGS) begin
                flags <= wb.data;
            end
        end
    end

endmodule

//--- hw/z8Sequencer.sv
`timescale 1ns/1ps
`include "z8Lite_defines.svh"

module z8Sequencer (
    input  logic                   clk,
    input  logic                   rstN,
    output logic                   memStrobe,
    output logic [`MEM_ADDR_W-1:0] memAddr,
    input  logic [7:0]             memData,
    output logic [7:0]             rdAddrA,
    output logic [7:0]             rdAddrB,
    input  logic [7:0]             rdDataA,
    input  logic [7:0]             rdDataB,
    output z8LitePkg::aluOpE       aluOp,
    output logic [7:0]             aluA,
    output logic [7:0]             aluB,
    input  logic [7:0]             aluOut,
    input  logic [7:0]             flags,
    output z8LitePkg::wbT          wb,
    output logic                   flagsWe,
    output logic [1:0]             carrySet
);

    import z8LitePkg::*;

    typedef enum logic [2:0] {
        sIdle,
        sFetch,
        sCapture,
        sDecode,
        sExec,
        sExec2
    } stateE;

    stateE            state;
    logic [`PC_W-1:0] pc;
    logic [1:0]       byteIdx;
    logic [3:0]       rpCur;
    opcodeU           instr;
    operandU          operand;
    logic [7:0]       imm3;

    logic             lastByte;
    logic             condBase;
    logic             takeBranch;
    logic             alu2Valid;
    aluOpE            alu2Op;
    logic [7:0]       wbAddr;
    logic             wbEn;
    logic [`PC_W-1:0] relPc;

    logic isLdR;
    logic isLdFull;
    logic isSrp;
    logic isAlu2;
    logic isDjnz;
    logic isJr;
    logic isFlagOp;

    function automatic logic [1:0] lenOf(input logic [3:0] form);
        if (form[3:1] == 3'b111) begin
            return 2'd1;
        end
        if (form[3:2] == 2'b01 || form == 4'hD) begin
            return 2'd3;
        end
        return 2'd2;
    endfunction

    assign memStrobe = (state == sFetch);
    assign memAddr   = pc[`MEM_ADDR_W-1:0];
    assign lastByte  = (byteIdx == 2'd0) ? (lenOf(memData[3:0]) == 2'd1)
                                         : (byteIdx + 2'd1 == lenOf(instr.aluForm.form));

    assign isLdR    = (instr.regForm.form == 4'hC);
    assign isLdFull = (instr.aluForm.form == 4'h6) && (instr.aluForm.op == 4'hE);
    assign isSrp    = (instr.aluForm.form == 4'h1) && (instr.aluForm.op == 4'h3);
    assign isAlu2   = (instr.aluForm.form == 4'h2) && alu2Valid;
    assign isDjnz   = (instr.regForm.form == 4'hA);
    assign isJr     = (instr.regForm.form == 4'hB);
    assign isFlagOp = (instr.regForm.form == 4'hF);

    assign relPc = pc + {{(`PC_W - 8){operand.disp[7]}}, operand.disp};

    // Decode spends its cycle reading rp through port A
    assign rdAddrA = (state == sDecode) ? ADDR_RP
                   : {WORK_PREFIX, isDjnz ? instr.regForm.num : operand.regPair.dst};
    assign rdAddrB = {WORK_PREFIX, operand.regPair.src};

    always_comb begin
        alu2Valid = 1'b1;
        case (instr.aluForm.op)
            4'h0: alu2Op = ALU_ADD;
            4'h1: alu2Op = ALU_ADC;
            4'h2: alu2Op = ALU_SUB;
            4'h3: alu2Op = ALU_SBC;
            4'h4: alu2Op = ALU_OR;
            4'h5: alu2Op = ALU_AND;
            4'hA: alu2Op = ALU_CP;
            4'hB: alu2Op = ALU_XOR;
            default: begin
                alu2Op    = ALU_LD;
                alu2Valid = 1'b0;
            end
        endcase
    end

    // cc 0..7, upper half is the inverse
    always_comb begin
        case (instr.regForm.num[2:0])
            3'd0: condBase = 1'b0;
            3'd1: condBase = flags[FLAG_S] ^ flags[FLAG_V];
            3'd2: condBase = (flags[FLAG_S] ^ flags[FLAG_V]) | flags[FLAG_Z];
            3'd3: condBase = flags[FLAG_C] | flags[FLAG_Z];
            3'd4: condBase = flags[FLAG_V];
            3'd5: condBase = flags[FLAG_S];
            3'd6: condBase = flags[FLAG_Z];
            default: condBase = flags[FLAG_C];
        endcase
        takeBranch = condBase ^ instr.regForm.num[3];
    end

    always_comb begin
        aluOp    = ALU_LD;
        aluA     = rdDataA;
        aluB     = rdDataB;
        wbAddr   = operand;
        wbEn     = 1'b0;
        flagsWe  = 1'b0;
        carrySet = CARRY_KEEP;
        if (state == sExec) begin
            if (isLdR) begin
                aluB   = operand;
                wbAddr = {WORK_PREFIX, instr.regForm.num};
                wbEn   = 1'b1;
            end else if (isLdFull) begin
                aluB = imm3;
                wbEn = 1'b1;
            end else if (isSrp) begin
                aluB   = operand;
                wbAddr = ADDR_RP;
                wbEn   = 1'b1;
            end else if (isAlu2) begin
                aluOp   = alu2Op;
                wbAddr  = {WORK_PREFIX, operand.regPair.dst};
                wbEn    = (alu2Op != ALU_CP);
                flagsWe = 1'b1;
            end else if (isDjnz) begin
                aluOp  = ALU_DEC;
                wbAddr = {WORK_PREFIX, instr.regForm.num};
                wbEn   = 1'b1;
            end else if (isFlagOp) begin
                case (instr.regForm.num)
                    4'hC: carrySet = CARRY_CLR;
                    4'hD: carrySet = CARRY_SET;
                    4'hE: carrySet = CARRY_CPL;
                    default: carrySet = CARRY_KEEP;
                endcase
            end
        end
        wb.valid = wbEn;
        wb.addr  = workAddr(wbAddr, rpCur);
        wb.data  = aluOut;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= sIdle;
            pc      <= `RESET_PC;
            byteIdx <= 2'd0;
            rpCur   <= 4'h0;
        end else begin
            case (state)
                sIdle: state <= sFetch;
                sFetch: state <= sCapture;
                sCapture: begin
                    pc <= pc + 1'b1;
                    if (lastByte) begin
                        byteIdx <= 2'd0;
                        state   <= sDecode;
                    end else begin
                        byteIdx <= byteIdx + 2'd1;
                        state   <= sFetch;
                    end
                end
                sDecode: begin
                    rpCur <= rdDataA[7:4];
                    state <= sExec;
                end
                sExec: begin
                    state <= isDjnz ? sExec2 : sFetch;
                    if (isJr && takeBranch) begin
                        pc <= relPc;
                    end
                end
                default: begin
                    // Register already holds the decremented count
                    state <= sFetch;
                    if (rdDataA != 8'h00) begin
                        pc <= relPc;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sCapture) begin
            case (byteIdx)
                2'd0: instr <= memData;
                2'd1: operand <= memData;
                default: imm3 <= memData;
            endcase
        end
    end

endmodule

//--- sim/z8LiteTb.sv
`timescale 1ns/1ps
`include "z8Lite_defines.svh"

module z8LiteTb;

    import z8LitePkg::*;

    localparam int WaitLimit = 100;

    logic                   clk;
    logic                   rstN;
    logic                   loadEn;
    logic [`MEM_ADDR_W-1:0] loadAddr;
    logic [7:0]             loadData;
    wbT                     wb;
    logic [7:0]             flags;

    logic [`MEM_ADDR_W-1:0] progAddr[$];
    logic [7:0]             progData[$];
    logic [7:0]             expKind[$];
    logic [7:0]             expAddr[$];
    logic [7:0]             expData[$];

    z8Lite dut (
        .clk      (clk),
        .rstN     (rstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .wb       (wb),
        .flags    (flags)
    );

    bind z8Sequencer z8LiteAssertions seqChecks (
        .clk       (clk),
        .rstN      (rstN),
        .memStrobe (memStrobe),
        .wb        (wb),
        .flagsWe   (flagsWe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            abortRun();
        end
    endtask

    // Golden lines: '#' comment, P addr byte, W addr data, F flags
    task automatic readGolden();
        int                fd;
        int                code;
        logic [7:0]        kind;
        logic [15:0]       first;
        logic [15:0]       second;
        logic [8*128-1:0]  skipped;
        fd = $fopen("sim/z8Lite_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file sim/z8Lite_golden.txt");
            abortRun();
        end else begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1) begin
                case (kind)
                    "#": begin
                        void'($fgets(skipped, fd));
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h", first, second);
                        progAddr.push_back(first[`MEM_ADDR_W-1:0]);
                        progData.push_back(second[7:0]);
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", first, second);
                        expKind.push_back(kind);
                        expAddr.push_back(first[7:0]);
                        expData.push_back(second[7:0]);
                    end
                    "F": begin
                        code = $fscanf(fd, "%h", second);
                        expKind.push_back(kind);
                        expAddr.push_back(8'h00);
                        expData.push_back(second[7:0]);
                    end
                    default: begin
                        $display("Golden file has a line of unknown kind '%c'", kind);
                        abortRun();
                    end
                endcase
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
    endtask

    // One byte per cycle while the core sits in reset
    task automatic loadProgram();
        foreach (progAddr[i]) begin
            loadEn   = 1'b1;
            loadAddr = progAddr[i];
            loadData = progData[i];
            @(negedge clk);
        end
        loadEn = 1'b0;
    endtask

    task automatic waitForWriteBack(input int entry);
        int cycles;
        cycles = 0;
        while (!wb.valid) begin
            if (cycles >= WaitLimit) begin
                $display("Timeout: no write-back within %0d cycles for golden entry %0d",
                         WaitLimit, entry);
                abortRun();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    initial begin
        int idx;
        rstN     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = 8'h00;
        readGolden();
        repeat (4) @(negedge clk);
        loadProgram();
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("wb.valid", 16'd0, wb.valid);
        checkValue("flags", 16'h00, flags);

        idx = 0;
        while (idx < expKind.size()) begin
            if (expKind[idx] == "W") begin
                waitForWriteBack(idx);
                checkValue("wb.addr", expAddr[idx], wb.addr);
                checkValue("wb.data", expData[idx], wb.data);
                // Flags settle on the edge that ends the write-back cycle
                @(negedge clk);
            end else begin
                checkValue("flags", expData[idx], flags);
            end
            idx++;
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- sim/z8Lite_assertions.sv
`timescale 1ns/1ps

module z8LiteAssertions (
    input logic          clk,
    input logic          rstN,
    input logic          memStrobe,
    input z8LitePkg::wbT wb,
    input logic          flagsWe
);

    // Fetch and write-back never overlap
    strobeWbExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(memStrobe && wb.valid)
    ) else $error("memStrobe and wb.valid high in the same cycle");

    noFlagsWriteInReset: assert property (
        @(posedge clk) !rstN |-> !flagsWe
    ) else $error("flagsWe high while rstN is low");

    wbSinglePulse: assert property (
        @(posedge clk) disable iff (!rstN) wb.valid |=> !wb.valid
    ) else $error("wb.valid held longer than one cycle");

endmodule

//--- sim/z8Lite_golden.txt
# P addr byte loads program memory, W addr data is the next write-back
# F flags is the flags output one cycle after the preceding W
P 0C 31
P 0D 20
P 0E 0C
P 0F 7F
P 10 1C
P 11 01
P 12 02
P 13 01
P 14 2C
P 15 FF
P 16 3C
P 17 02
P 18 4C
P 19 FE
P 1A 02
P 1B 23
P 1C 12
P 1D 41
P 1E 5C
P 1F 05
P 20 22
P 21 35
P 22 32
P 23 01
P 24 42
P 25 03
P 26 52
P 27 24
P 28 A2
P 29 15
P 2A 6C
P 2B 5A
P 2C CF
P 2D 6C
P 2E 11
P 2F DF
P 30 6C
P 31 22
P 32 EF
P 33 6C
P 34 33
P 35 B2
P 36 66
P 37 6B
P 38 02
P 39 7C
P 3A 11
P 3B 7C
P 3C 22
P 3D EB
P 3E 02
P 3F 7C
P 40 33
P 41 FB
P 42 02
P 43 7C
P 44 44
P 45 8C
P 46 03
P 47 8A
P 48 FE
P 49 31
P 4A 30
P 4B 0C
P 4C 66
P 4D E6
P 4E 45
P 4F 99
P 50 8B
P 51 FE
# srp, loads and two-register ALU ops
W FD 20
W 20 7F
W 21 01
W 20 80
F 30
W 22 FF
W 23 02
W 24 FE
W 22 01
F 80
W 24 00
F C0
W 25 05
W 23 FD
F A0
W 20 7E
F 10
W 20 FF
F 20
W 22 00
F 40
# cp then carry ops, each seen after a load
W 26 5A
F A0
W 26 11
F 20
W 26 22
F A0
W 26 33
F 20
W 26 00
F 40
# jr z taken, jr nz not taken, jr nc taken
W 27 22
W 27 33
W 28 03
# djnz count down
W 28 02
W 28 01
W 28 00
W FD 30
W 30 66
W 45 99

//--- z8Lite.f
+incdir+hw
hw/z8LitePkg.sv
hw/z8ProgMem.sv
hw/z8RegFile.sv
hw/z8Alu.sv
hw/z8Sequencer.sv
hw/z8Lite.sv
sim/z8Lite_assertions.sv
sim/z8LiteTb.sv
